// ==== common/fm_pkg.sv ====
// sizes, host address map, response codes, channel payload types and init pattern
package fm_pkg;

	localparam int NUM_CHANNELS     = 4; // monitoring channels
	localparam int NUM_HIT_CHANNELS = 2; // ch 0..1 hits, rest candidates
	localparam int CH_W             = $clog2(NUM_CHANNELS); // channel select bits

	localparam int AXI_DW = 32; // host data width
	localparam int AXI_AW = 12; // host byte address width

	localparam int SPY_DEPTH = 64; // entries per spy memory
	localparam int SPY_AW    = 6; // log2 of SPY_DEPTH
	localparam int FIFO_DEPTH = 8; // passthrough entries

	// memory window is channel in [9:8], entry in [7:2]
	localparam int SPY_ENTRY_LSB = 2; // word aligned
	localparam int SPY_CH_LSB    = SPY_ENTRY_LSB + SPY_AW;
	localparam int MEM_SPAN      = NUM_CHANNELS * SPY_DEPTH * (AXI_DW / 8); // 0x400 bytes

	localparam logic [AXI_AW-1:0] CTRL_ADDR = 12'h400; // control/status register
	localparam int CTRL_INIT_BIT = 8; // sweep start on write, busy on read

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef logic [AXI_DW-1:0] axi_data_t; // host word
	typedef logic [SPY_AW-1:0] spy_addr_t; // spy memory entry

	localparam axi_data_t INIT_PATTERN = 32'h0FA5FA50; // sweep fill value

	// drift tube hit, 24 bits
	typedef struct packed {
		logic [3:0]  layer; // tube layer in chamber
		logic [8:0]  tube; // tube number in layer
		logic [10:0] tdc; // drift time count
	} mdt_hit_t;

	// trigger candidate, 16 bits
	typedef struct packed {
		logic [5:0] phi; // phi segment
		logic [5:0] eta; // eta segment
		logic [3:0] pt_thr; // passed pt threshold
	} l0_cand_t;

endpackage

// ==== spy_buffer/fm_passthrough_fifo.sv ====
// eight entry valid/ready FIFO forwarding one channel downstream
`timescale 1ns/100ps

module fm_passthrough_fifo #(
	parameter type payload_t = fm_pkg::mdt_hit_t
) (
	input  logic     spy_clock,
	input  logic     axi_reset_n,
	input  payload_t in_data_i,
	input  logic     in_valid_i,
	output logic     in_ready_o,
	output payload_t out_data_o,
	output logic     out_valid_o,
	input  logic     out_ready_i
);
	import fm_pkg::*;

	payload_t                      mem [FIFO_DEPTH]; // entry storage
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q; // head entry
	logic [$clog2(FIFO_DEPTH):0]   count_q; // 0..FIFO_DEPTH
	logic                          push;
	logic                          pop;

	assign in_ready_o  = (count_q != FIFO_DEPTH); // low only when full
	assign out_valid_o = (count_q != 0);
	assign out_data_o  = mem[rd_ptr_q]; // head straight from storage regs

	assign push = in_valid_i && in_ready_o;
	assign pop  = out_valid_o && out_ready_i;

	always_ff @(posedge spy_clock)
	begin
		if (push)
			mem[wr_ptr_q] <= in_data_i;
	end

	always_ff @(posedge spy_clock)
	begin
		if (!axi_reset_n)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at depth
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			if (push && !pop)
				count_q <= count_q + 1'b1;
			else if (pop && !push)
				count_q <= count_q - 1'b1;
		end
	end

	a_no_ovf_unf: assert property (@(posedge spy_clock) disable iff (!axi_reset_n)
		!(push && count_q == FIFO_DEPTH) && !(pop && count_q == 0));

endmodule

// ==== spy_buffer/fm_spy_buffer.sv ====
// circular capture memory per channel with host read/write port
`timescale 1ns/100ps

module fm_spy_buffer #(
	parameter type payload_t = fm_pkg::mdt_hit_t
) (
	input  logic              spy_clock,
	input  logic              axi_reset_n,
	input  payload_t          cap_data_i,
	input  logic              cap_valid_i,
	input  logic              freeze_i,
	input  logic              spy_en_i,
	input  logic              spy_wen_i,
	input  fm_pkg::spy_addr_t spy_addr_i,
	input  fm_pkg::axi_data_t spy_wdata_i,
	output fm_pkg::axi_data_t spy_rdata_o
);
	import fm_pkg::*;

	axi_data_t mem [SPY_DEPTH]; // spy storage
	spy_addr_t wr_ptr_q; // next capture entry
	axi_data_t cap_word; // payload widened to host word
	logic      cap_we; // capture write this cycle
	logic      host_we; // host or sweep write this cycle

	// upper bits stay zero
	always_comb
	begin
		cap_word = '0;
		cap_word[$bits(payload_t)-1:0] = cap_data_i;
	end

	assign cap_we  = cap_valid_i && !freeze_i; // frozen channel keeps its history
	assign host_we = spy_en_i && spy_wen_i;

	// write pointer wraps over the 64 entries
	always_ff @(posedge spy_clock)
	begin
		if (!axi_reset_n)
			wr_ptr_q <= '0;
		else if (cap_we)
			wr_ptr_q <= wr_ptr_q + 1'b1;
	end

	// capture port and host port
	always_ff @(posedge spy_clock)
	begin
		if (cap_we)
			mem[wr_ptr_q] <= cap_word;
		if (host_we)
			mem[spy_addr_i] <= spy_wdata_i; // host wins on same entry
	end

	// host read, one cycle after spy_en
	always_ff @(posedge spy_clock)
	begin
		if (spy_en_i)
			spy_rdata_o <= mem[spy_addr_i]; // old value on a write cycle
	end

	a_freeze_hold: assert property (@(posedge spy_clock) disable iff (!axi_reset_n)
		freeze_i |=> $stable(wr_ptr_q));

endmodule

// ==== rtl/fm_host_ctrl.sv ====
// AXI4-Lite slave with address decode, freeze register, init sweep and readback select
`timescale 1ns/100ps

module fm_host_ctrl (
	input  logic                          spy_clock,
	input  logic                          axi_reset_n,
	input  logic [fm_pkg::AXI_AW-1:0]     s_axil_awaddr_i,
	input  logic                          s_axil_awvalid_i,
	output logic                          s_axil_awready_o,
	input  fm_pkg::axi_data_t             s_axil_wdata_i,
	input  logic                          s_axil_wvalid_i,
	output logic                          s_axil_wready_o,
	output logic [1:0]                    s_axil_bresp_o,
	output logic                          s_axil_bvalid_o,
	input  logic                          s_axil_bready_i,
	input  logic [fm_pkg::AXI_AW-1:0]     s_axil_araddr_i,
	input  logic                          s_axil_arvalid_i,
	output logic                          s_axil_arready_o,
	output fm_pkg::axi_data_t             s_axil_rdata_o,
	output logic [1:0]                    s_axil_rresp_o,
	output logic                          s_axil_rvalid_o,
	input  logic                          s_axil_rready_i,
	output logic [fm_pkg::NUM_CHANNELS-1:0] spy_en_o,
	output logic                          spy_wen_o,
	output fm_pkg::spy_addr_t             spy_addr_o,
	output fm_pkg::axi_data_t             spy_wdata_o,
	input  fm_pkg::axi_data_t             spy_rdata_i [fm_pkg::NUM_CHANNELS],
	output logic [fm_pkg::NUM_CHANNELS-1:0] freeze_o
);
	import fm_pkg::*;

	logic                    busy_q; // init sweep running
	spy_addr_t               sweep_cnt_q; // sweep entry
	logic [NUM_CHANNELS-1:0] freeze_q; // freeze mask
	logic                    bvalid_q;
	logic [1:0]              bresp_q;
	logic                    rd_pend_q; // memory read in flight
	logic                    rd_mem_q; // pending read hits a spy memory
	logic                    rd_ctrl_q; // pending read hits the status word
	logic [CH_W-1:0]         rd_ch_q; // channel for readback mux
	logic                    rvalid_q;
	axi_data_t               rdata_q;
	logic [1:0]              rresp_q;
	logic                    idle; // nothing outstanding
	logic                    wr_acc;
	logic                    rd_acc;
	logic                    aw_mem;
	logic                    aw_ctrl;
	logic                    ar_mem;
	logic                    ar_ctrl;
	logic [CH_W-1:0]         aw_ch;
	logic [CH_W-1:0]         ar_ch;
	axi_data_t               status; // control/status readback

	// one transaction at a time, none during the sweep
	assign idle   = !busy_q && !bvalid_q && !rd_pend_q && !rvalid_q;
	assign wr_acc = idle && s_axil_awvalid_i && s_axil_wvalid_i;
	assign rd_acc = idle && s_axil_arvalid_i && !(s_axil_awvalid_i && s_axil_wvalid_i); // write wins

	assign s_axil_awready_o = wr_acc; // aw and w taken together
	assign s_axil_wready_o  = wr_acc;
	assign s_axil_arready_o = rd_acc;

	assign aw_mem  = (s_axil_awaddr_i < MEM_SPAN);
	assign aw_ctrl = (s_axil_awaddr_i == CTRL_ADDR);
	assign aw_ch   = s_axil_awaddr_i[SPY_CH_LSB +: CH_W];
	assign ar_mem  = (s_axil_araddr_i < MEM_SPAN);
	assign ar_ctrl = (s_axil_araddr_i == CTRL_ADDR);
	assign ar_ch   = s_axil_araddr_i[SPY_CH_LSB +: CH_W];

	// spy bus is driven in the accept cycle, sweep owns it while busy
	always_comb
	begin
		spy_wen_o   = busy_q || (wr_acc && aw_mem);
		spy_wdata_o = busy_q ? INIT_PATTERN : s_axil_wdata_i;
		if (busy_q)
			spy_addr_o = sweep_cnt_q;
		else if (wr_acc)
			spy_addr_o = s_axil_awaddr_i[SPY_ENTRY_LSB +: SPY_AW];
		else
			spy_addr_o = s_axil_araddr_i[SPY_ENTRY_LSB +: SPY_AW];
		for (int i = 0; i < NUM_CHANNELS; i++)
		begin
			spy_en_o[i] = busy_q || (wr_acc && aw_mem && aw_ch == CH_W'(i)) ||
				(rd_acc && ar_mem && ar_ch == CH_W'(i));
		end
	end

	always_comb
	begin
		status = '0;
		status[NUM_CHANNELS-1:0] = freeze_q;
		status[CTRL_INIT_BIT]    = busy_q;
	end

	// freeze mask and sweep counter, sweep runs right out of reset
	always_ff @(posedge spy_clock)
	begin
		if (!axi_reset_n)
		begin
			busy_q      <= 1'b1;
			sweep_cnt_q <= '0;
			freeze_q    <= '0;
		end
		else
		begin
			if (busy_q)
			begin
				sweep_cnt_q <= sweep_cnt_q + 1'b1; // wraps back to 0
				if (sweep_cnt_q == SPY_AW'(SPY_DEPTH - 1))
					busy_q <= 1'b0;
			end
			if (wr_acc && aw_ctrl)
			begin
				freeze_q <= s_axil_wdata_i[NUM_CHANNELS-1:0];
				if (s_axil_wdata_i[CTRL_INIT_BIT])
					busy_q <= 1'b1; // sweep starts next cycle
			end
		end
	end

	// response handshakes
	always_ff @(posedge spy_clock)
	begin
		if (!axi_reset_n)
		begin
			bvalid_q  <= 1'b0;
			rd_pend_q <= 1'b0;
			rvalid_q  <= 1'b0;
		end
		else
		begin
			if (wr_acc)
				bvalid_q <= 1'b1;
			else if (s_axil_bready_i)
				bvalid_q <= 1'b0;
			rd_pend_q <= rd_acc; // memory read cycle
			if (rd_pend_q)
				rvalid_q <= 1'b1; // select cycle done
			else if (s_axil_rready_i)
				rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge spy_clock)
	begin
		if (wr_acc)
			bresp_q <= (aw_mem || aw_ctrl) ? RESP_OKAY : RESP_SLVERR;
		if (rd_acc)
		begin
			rd_mem_q  <= ar_mem;
			rd_ctrl_q <= ar_ctrl;
			rd_ch_q   <= ar_ch;
		end
		if (rd_pend_q)
		begin
			rdata_q <= rd_mem_q ? spy_rdata_i[rd_ch_q] : (rd_ctrl_q ? status : '0);
			rresp_q <= (rd_mem_q || rd_ctrl_q) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	assign s_axil_bvalid_o = bvalid_q;
	assign s_axil_bresp_o  = bresp_q;
	assign s_axil_rvalid_o = rvalid_q;
	assign s_axil_rdata_o  = rdata_q;
	assign s_axil_rresp_o  = rresp_q;
	assign freeze_o        = freeze_q;

	a_rd_latency: assert property (@(posedge spy_clock) disable iff (!axi_reset_n)
		(s_axil_arvalid_i && s_axil_arready_o) |-> ##2 s_axil_rvalid_o);

	a_r_hold: assert property (@(posedge spy_clock) disable iff (!axi_reset_n)
		(s_axil_rvalid_o && !s_axil_rready_i) |=>
		(s_axil_rvalid_o && $stable(s_axil_rdata_o) && $stable(s_axil_rresp_o)));

endmodule

// ==== rtl/fm_top.sv ====
// top level with host controller, spy buffers and passthrough FIFOs of all four channels
`timescale 1ns/100ps

module fm_top (
	input  logic                       spy_clock,
	input  logic                       axi_reset_n,
	input  logic [fm_pkg::AXI_AW-1:0]  s_axil_awaddr_i,
	input  logic                       s_axil_awvalid_i,
	output logic                       s_axil_awready_o,
	input  fm_pkg::axi_data_t          s_axil_wdata_i,
	input  logic                       s_axil_wvalid_i,
	output logic                       s_axil_wready_o,
	output logic [1:0]                 s_axil_bresp_o,
	output logic                       s_axil_bvalid_o,
	input  logic                       s_axil_bready_i,
	input  logic [fm_pkg::AXI_AW-1:0]  s_axil_araddr_i,
	input  logic                       s_axil_arvalid_i,
	output logic                       s_axil_arready_o,
	output fm_pkg::axi_data_t          s_axil_rdata_o,
	output logic [1:0]                 s_axil_rresp_o,
	output logic                       s_axil_rvalid_o,
	input  logic                       s_axil_rready_i,
	input  fm_pkg::mdt_hit_t           hit_data_i [fm_pkg::NUM_HIT_CHANNELS],
	input  logic [fm_pkg::NUM_HIT_CHANNELS-1:0] hit_valid_i,
	output logic [fm_pkg::NUM_HIT_CHANNELS-1:0] hit_ready_o,
	output fm_pkg::mdt_hit_t           hit_data_o [fm_pkg::NUM_HIT_CHANNELS],
	output logic [fm_pkg::NUM_HIT_CHANNELS-1:0] hit_valid_o,
	input  logic [fm_pkg::NUM_HIT_CHANNELS-1:0] hit_ready_i,
	input  fm_pkg::l0_cand_t           cand_data_i [fm_pkg::NUM_CHANNELS-fm_pkg::NUM_HIT_CHANNELS],
	input  logic [fm_pkg::NUM_CHANNELS-fm_pkg::NUM_HIT_CHANNELS-1:0] cand_valid_i,
	output logic [fm_pkg::NUM_CHANNELS-fm_pkg::NUM_HIT_CHANNELS-1:0] cand_ready_o,
	output fm_pkg::l0_cand_t           cand_data_o [fm_pkg::NUM_CHANNELS-fm_pkg::NUM_HIT_CHANNELS],
	output logic [fm_pkg::NUM_CHANNELS-fm_pkg::NUM_HIT_CHANNELS-1:0] cand_valid_o,
	input  logic [fm_pkg::NUM_CHANNELS-fm_pkg::NUM_HIT_CHANNELS-1:0] cand_ready_i
);
	import fm_pkg::*;

	logic [NUM_CHANNELS-1:0] spy_en; // one-hot host select, all ones in sweep
	logic                    spy_wen; // shared host write strobe
	spy_addr_t               spy_addr; // shared entry
	axi_data_t               spy_wdata; // shared write word
	axi_data_t               spy_rdata [NUM_CHANNELS]; // per channel readback
	logic [NUM_CHANNELS-1:0] freeze; // capture hold per channel

	fm_host_ctrl host_ctrl_i (
		.spy_clock        (spy_clock),
		.axi_reset_n      (axi_reset_n),
		.s_axil_awaddr_i  (s_axil_awaddr_i),
		.s_axil_awvalid_i (s_axil_awvalid_i),
		.s_axil_awready_o (s_axil_awready_o),
		.s_axil_wdata_i   (s_axil_wdata_i),
		.s_axil_wvalid_i  (s_axil_wvalid_i),
		.s_axil_wready_o  (s_axil_wready_o),
		.s_axil_bresp_o   (s_axil_bresp_o),
		.s_axil_bvalid_o  (s_axil_bvalid_o),
		.s_axil_bready_i  (s_axil_bready_i),
		.s_axil_araddr_i  (s_axil_araddr_i),
		.s_axil_arvalid_i (s_axil_arvalid_i),
		.s_axil_arready_o (s_axil_arready_o),
		.s_axil_rdata_o   (s_axil_rdata_o),
		.s_axil_rresp_o   (s_axil_rresp_o),
		.s_axil_rvalid_o  (s_axil_rvalid_o),
		.s_axil_rready_i  (s_axil_rready_i),
		.spy_en_o         (spy_en),
		.spy_wen_o        (spy_wen),
		.spy_addr_o       (spy_addr),
		.spy_wdata_o      (spy_wdata),
		.spy_rdata_i      (spy_rdata),
		.freeze_o         (freeze)
	);

	// hit channels sit at 0..NUM_HIT_CHANNELS-1
	for (genvar g = 0; g < NUM_HIT_CHANNELS; g++)
	begin : g_hit
		fm_passthrough_fifo #(.payload_t(mdt_hit_t)) fifo_i (
			.spy_clock   (spy_clock),
			.axi_reset_n (axi_reset_n),
			.in_data_i   (hit_data_i[g]),
			.in_valid_i  (hit_valid_i[g]),
			.in_ready_o  (hit_ready_o[g]),
			.out_data_o  (hit_data_o[g]),
			.out_valid_o (hit_valid_o[g]),
			.out_ready_i (hit_ready_i[g])
		);

		fm_spy_buffer #(.payload_t(mdt_hit_t)) spy_i (
			.spy_clock   (spy_clock),
			.axi_reset_n (axi_reset_n),
			.cap_data_i  (hit_data_i[g]),
			.cap_valid_i (hit_valid_i[g] && hit_ready_o[g]), // same accept as the FIFO
			.freeze_i    (freeze[g]),
			.spy_en_i    (spy_en[g]),
			.spy_wen_i   (spy_wen),
			.spy_addr_i  (spy_addr),
			.spy_wdata_i (spy_wdata),
			.spy_rdata_o (spy_rdata[g])
		);
	end

	// candidate channels follow the hits
	for (genvar g = 0; g < NUM_CHANNELS - NUM_HIT_CHANNELS; g++)
	begin : g_cand
		fm_passthrough_fifo #(.payload_t(l0_cand_t)) fifo_i (
			.spy_clock   (spy_clock),
			.axi_reset_n (axi_reset_n),
			.in_data_i   (cand_data_i[g]),
			.in_valid_i  (cand_valid_i[g]),
			.in_ready_o  (cand_ready_o[g]),
			.out_data_o  (cand_data_o[g]),
			.out_valid_o (cand_valid_o[g]),
			.out_ready_i (cand_ready_i[g])
		);

		fm_spy_buffer #(.payload_t(l0_cand_t)) spy_i (
			.spy_clock   (spy_clock),
			.axi_reset_n (axi_reset_n),
			.cap_data_i  (cand_data_i[g]),
			.cap_valid_i (cand_valid_i[g] && cand_ready_o[g]),
			.freeze_i    (freeze[NUM_HIT_CHANNELS+g]),
			.spy_en_i    (spy_en[NUM_HIT_CHANNELS+g]),
			.spy_wen_i   (spy_wen),
			.spy_addr_i  (spy_addr),
			.spy_wdata_i (spy_wdata),
			.spy_rdata_o (spy_rdata[NUM_HIT_CHANNELS+g])
		);
	end

endmodule

// ==== verification/fm_tb_model.svh ====
// reference model of spy memory contents, host address decode and expected channel queues
`ifndef FM_TB_MODEL_SVH
`define FM_TB_MODEL_SVH

axi_data_t               spy_model [NUM_CHANNELS][SPY_DEPTH]; // expected memory contents
int unsigned             model_ptr [NUM_CHANNELS]; // expected capture pointers
logic [NUM_CHANNELS-1:0] model_freeze; // expected freeze mask
mdt_hit_t                hit_exp_q [NUM_HIT_CHANNELS][$]; // words owed per hit channel
l0_cand_t                cand_exp_q [NUM_CHANNELS-NUM_HIT_CHANNELS][$];
axi_data_t               exp_rdata_q [$]; // one per outstanding read
logic [1:0]              exp_rresp_q [$];
logic [1:0]              exp_bresp_q [$];

// memory window 0x000..0x3FF
function automatic logic is_mem_addr(logic [AXI_AW-1:0] addr);
	return addr <= 12'h3FF;
endfunction

function automatic logic is_ctrl_addr(logic [AXI_AW-1:0] addr);
	return addr == CTRL_ADDR;
endfunction

function automatic logic [1:0] expected_resp(logic [AXI_AW-1:0] addr);
	return (is_mem_addr(addr) || is_ctrl_addr(addr)) ? RESP_OKAY : RESP_SLVERR;
endfunction

// reads are only taken when the sweep is idle so busy reads back 0
function automatic axi_data_t expected_rdata(logic [AXI_AW-1:0] addr);
	if (is_mem_addr(addr))
		return spy_model[addr[9:8]][addr[7:2]]; // channel, entry
	if (is_ctrl_addr(addr))
		return {28'h0, model_freeze};
	return 32'h0;
endfunction

function automatic axi_data_t widen_hit(mdt_hit_t h);
	return {8'h00, h}; // 24 bit hit
endfunction

function automatic axi_data_t widen_cand(l0_cand_t c);
	return {16'h0000, c}; // 16 bit candidate
endfunction

function automatic void model_fill_all();
	for (int c = 0; c < NUM_CHANNELS; c++)
		for (int e = 0; e < SPY_DEPTH; e++)
			spy_model[c][e] = INIT_PATTERN;
endfunction

function automatic void model_capture(int ch, axi_data_t word);
	if (!model_freeze[ch])
	begin
		spy_model[ch][model_ptr[ch]] = word;
		model_ptr[ch] = (model_ptr[ch] + 1) % SPY_DEPTH; // circular
	end
endfunction

function automatic void model_host_write(logic [AXI_AW-1:0] addr, axi_data_t data);
	if (is_mem_addr(addr))
		spy_model[addr[9:8]][addr[7:2]] = data;
	else if (is_ctrl_addr(addr))
	begin
		model_freeze = data[3:0];
		if (data[8])
			model_fill_all(); // sweep request
	end
endfunction

`endif

// ==== verification/fm_tb.sv ====
// testbench with clock, reset, host bus tasks, channel traffic, compare process and watchdog
`timescale 1ns/100ps

module fm_tb;
	import fm_pkg::*;

	localparam time CLK_PERIOD  = 100ns;
	localparam int  N_CAND      = NUM_CHANNELS - NUM_HIT_CHANNELS;
	localparam int  TRAFFIC_CYC = 60; // keeps a capture run under 64 words
	localparam int  DUMP_CYC    = NUM_CHANNELS * SPY_DEPTH * 6; // up to 6 cycles per read
	localparam int  TOTAL_CYC   = (SPY_DEPTH + 16 + DUMP_CYC) + (TRAFFIC_CYC + 32 + DUMP_CYC) +
		(24 + TRAFFIC_CYC + 32 + DUMP_CYC) + (4 * TRAFFIC_CYC + 32) +
		(16 * 12 + SPY_DEPTH + DUMP_CYC) + 48;

	logic spy_clock;
	logic axi_reset_n;
	logic [AXI_AW-1:0] awaddr;
	logic awvalid;
	logic awready;
	axi_data_t wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [AXI_AW-1:0] araddr;
	logic arvalid;
	logic arready;
	axi_data_t rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	mdt_hit_t hit_in [NUM_HIT_CHANNELS];
	logic [NUM_HIT_CHANNELS-1:0] hit_in_valid;
	logic [NUM_HIT_CHANNELS-1:0] hit_in_ready;
	mdt_hit_t hit_out [NUM_HIT_CHANNELS];
	logic [NUM_HIT_CHANNELS-1:0] hit_out_valid;
	logic [NUM_HIT_CHANNELS-1:0] hit_out_ready;
	l0_cand_t cand_in [N_CAND];
	logic [N_CAND-1:0] cand_in_valid;
	logic [N_CAND-1:0] cand_in_ready;
	l0_cand_t cand_out [N_CAND];
	logic [N_CAND-1:0] cand_out_valid;
	logic [N_CAND-1:0] cand_out_ready;
	logic [NUM_CHANNELS-1:0] in_taken; // input word taken at the coming edge
	int err_cnt;
	int check_cnt;
	int test_err_base; // errors before the running test

	`include "fm_tb_model.svh"

	fm_top fm_top_i (
		.spy_clock (spy_clock), .axi_reset_n (axi_reset_n),
		.s_axil_awaddr_i (awaddr), .s_axil_awvalid_i (awvalid), .s_axil_awready_o (awready),
		.s_axil_wdata_i (wdata), .s_axil_wvalid_i (wvalid), .s_axil_wready_o (wready),
		.s_axil_bresp_o (bresp), .s_axil_bvalid_o (bvalid), .s_axil_bready_i (bready),
		.s_axil_araddr_i (araddr), .s_axil_arvalid_i (arvalid), .s_axil_arready_o (arready),
		.s_axil_rdata_o (rdata), .s_axil_rresp_o (rresp), .s_axil_rvalid_o (rvalid),
		.s_axil_rready_i (rready),
		.hit_data_i (hit_in), .hit_valid_i (hit_in_valid), .hit_ready_o (hit_in_ready),
		.hit_data_o (hit_out), .hit_valid_o (hit_out_valid), .hit_ready_i (hit_out_ready),
		.cand_data_i (cand_in), .cand_valid_i (cand_in_valid), .cand_ready_o (cand_in_ready),
		.cand_data_o (cand_out), .cand_valid_o (cand_out_valid), .cand_ready_i (cand_out_ready)
	);

	always #(CLK_PERIOD / 2) spy_clock = ~spy_clock;

	task automatic hit_check(string name, mdt_hit_t got, mdt_hit_t exp);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("FAILED %s: got 0x%06h expected 0x%06h", name, got, exp);
		end
	endtask

	task automatic cand_check(string name, l0_cand_t got, l0_cand_t exp);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("FAILED %s: got 0x%04h expected 0x%04h", name, got, exp);
		end
	endtask

	task automatic word_check(string name, axi_data_t got, axi_data_t exp);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic resp_check(string name, logic [1:0] got, logic [1:0] exp);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("FAILED %s: got 0x%01h expected 0x%01h", name, got, exp);
		end
	endtask

	// handshakes seen here complete at the next rising edge
	always @(negedge spy_clock)
	begin
		if (axi_reset_n)
		begin
			for (int c = 0; c < NUM_HIT_CHANNELS; c++)
			begin
				if (hit_out_valid[c] && hit_out_ready[c])
				begin
					if (hit_exp_q[c].size() == 0)
					begin
						err_cnt++;
						$display("hit channel %0d forwarded a word it never accepted", c);
					end
					else
						hit_check($sformatf("hit_data_o[%0d]", c), hit_out[c],
							hit_exp_q[c].pop_front());
				end
				if (hit_in_valid[c] && hit_in_ready[c])
				begin
					hit_exp_q[c].push_back(hit_in[c]);
					model_capture(c, widen_hit(hit_in[c]));
				end
				in_taken[c] = hit_in_valid[c] && hit_in_ready[c];
			end
			for (int c = 0; c < N_CAND; c++)
			begin
				if (cand_out_valid[c] && cand_out_ready[c])
				begin
					if (cand_exp_q[c].size() == 0)
					begin
						err_cnt++;
						$display("candidate channel %0d forwarded a word it never accepted", c);
					end
					else
						cand_check($sformatf("cand_data_o[%0d]", c), cand_out[c],
							cand_exp_q[c].pop_front());
				end
				if (cand_in_valid[c] && cand_in_ready[c])
				begin
					cand_exp_q[c].push_back(cand_in[c]);
					model_capture(NUM_HIT_CHANNELS + c, widen_cand(cand_in[c]));
				end
				in_taken[NUM_HIT_CHANNELS+c] = cand_in_valid[c] && cand_in_ready[c];
			end
			if (rvalid && rready)
			begin
				if (exp_rdata_q.size() == 0)
				begin
					err_cnt++;
					$display("read response arrived with no read outstanding");
				end
				else
				begin
					word_check("s_axil_rdata_o", rdata, exp_rdata_q.pop_front());
					resp_check("s_axil_rresp_o", rresp, exp_rresp_q.pop_front());
				end
			end
			if (bvalid && bready)
			begin
				if (exp_bresp_q.size() == 0)
				begin
					err_cnt++;
					$display("write response arrived with no write outstanding");
				end
				else
					resp_check("s_axil_bresp_o", bresp, exp_bresp_q.pop_front());
			end
		end
	end

	function automatic int pending_words();
		int n;
		n = 0;
		for (int c = 0; c < NUM_HIT_CHANNELS; c++)
			n += hit_exp_q[c].size();
		for (int c = 0; c < N_CAND; c++)
			n += cand_exp_q[c].size();
		return n;
	endfunction

	task automatic write_word(input logic [AXI_AW-1:0] addr, input axi_data_t data);
		exp_bresp_q.push_back(expected_resp(addr));
		@(posedge spy_clock);
		#1;
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1; // aw and w offered together
		wvalid  = 1'b1;
		do
			@(negedge spy_clock);
		while (!awready && !wready);
		check_cnt++;
		if (awready !== wready)
		begin
			err_cnt++;
			$display("awready and wready did not rise in the same cycle");
		end
		@(posedge spy_clock);
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		do
			@(negedge spy_clock);
		while (!bvalid);
		@(posedge spy_clock);
		model_host_write(addr, data);
	endtask

	task automatic read_word(input logic [AXI_AW-1:0] addr, output axi_data_t data);
		exp_rdata_q.push_back(expected_rdata(addr));
		exp_rresp_q.push_back(expected_resp(addr));
		@(posedge spy_clock);
		#1;
		araddr  = addr;
		arvalid = 1'b1;
		do
			@(negedge spy_clock);
		while (!arready); // held off during the sweep
		@(posedge spy_clock);
		#1;
		arvalid = 1'b0;
		do
			@(negedge spy_clock);
		while (!rvalid);
		data = rdata;
		@(posedge spy_clock);
	endtask

	task automatic read_all_entries();
		axi_data_t data;
		for (int c = 0; c < NUM_CHANNELS; c++)
			for (int e = 0; e < SPY_DEPTH; e++)
				read_word(AXI_AW'(c * 256 + e * 4), data); // channel in 9..8, entry in 7..2
	endtask

	task automatic wait_sweep_done();
		axi_data_t status;
		do
			read_word(CTRL_ADDR, status);
		while (status[8]);
	endtask

	// random words on all channels, then drain every FIFO
	task automatic run_traffic(input int cycles, input bit random_ready);
		for (int n = 0; n < cycles; n++)
		begin
			@(posedge spy_clock);
			#1;
			for (int c = 0; c < NUM_HIT_CHANNELS; c++)
			begin
				if (!hit_in_valid[c] || in_taken[c])
				begin
					hit_in_valid[c] = ($urandom % 4) != 0; // busy about 3 cycles in 4
					hit_in[c]       = 24'($urandom);
				end
				hit_out_ready[c] = random_ready ? 1'($urandom) : 1'b1;
			end
			for (int c = 0; c < N_CAND; c++)
			begin
				if (!cand_in_valid[c] || in_taken[NUM_HIT_CHANNELS+c])
				begin
					cand_in_valid[c] = ($urandom % 4) != 0;
					cand_in[c]       = 16'($urandom);
				end
				cand_out_ready[c] = random_ready ? 1'($urandom) : 1'b1;
			end
		end
		@(posedge spy_clock);
		#1;
		hit_in_valid   = '0;
		cand_in_valid  = '0;
		hit_out_ready  = '1;
		cand_out_ready = '1;
		while (pending_words() != 0)
			@(negedge spy_clock);
		@(posedge spy_clock);
	endtask

	task automatic report_test(string name);
		if (err_cnt == test_err_base)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, err_cnt - test_err_base);
		test_err_base = err_cnt;
	endtask

	initial
	begin
		logic [AXI_AW-1:0] addr;
		axi_data_t wr;
		axi_data_t rd;
		void'($urandom(68414));
		spy_clock      = 1'b0;
		axi_reset_n    = 1'b0;
		awaddr         = '0;
		awvalid        = 1'b0;
		wdata          = '0;
		wvalid         = 1'b0;
		bready         = 1'b1;
		araddr         = '0;
		arvalid        = 1'b0;
		rready         = 1'b1;
		hit_in         = '{default: '0};
		hit_in_valid   = '0;
		hit_out_ready  = '1;
		cand_in        = '{default: '0};
		cand_in_valid  = '0;
		cand_out_ready = '1;
		in_taken       = '0;
		err_cnt        = 0;
		check_cnt      = 0;
		test_err_base  = 0;
		model_freeze   = '0;
		model_ptr      = '{default: 0};
		model_fill_all(); // sweep runs right after reset
		repeat (8) @(posedge spy_clock);
		#1;
		axi_reset_n = 1'b1;

		wait_sweep_done();
		read_all_entries();
		report_test("init sweep");

		run_traffic(TRAFFIC_CYC, 1'b0);
		read_all_entries();
		report_test("capture");

		write_word(CTRL_ADDR, 32'h0000_0006); // freeze ch 1 and 2
		run_traffic(TRAFFIC_CYC, 1'b0);
		read_all_entries();
		write_word(CTRL_ADDR, 32'h0000_0000);
		report_test("freeze");

		run_traffic(4 * TRAFFIC_CYC, 1'b1);
		report_test("passthrough back-pressure");

		for (int n = 0; n < 16; n++)
		begin
			addr = AXI_AW'(($urandom % 256) * 4);
			wr   = $urandom;
			write_word(addr, wr);
			read_word(addr, rd);
		end
		write_word(CTRL_ADDR, 32'h0000_0100); // sweep request
		wait_sweep_done();
		read_all_entries();
		report_test("host access");

		write_word(12'h404, 32'hDEAD_BEEF);
		write_word(12'hFFC, 32'h1234_5678);
		read_word(12'h404, rd);
		read_word(12'h800, rd);
		read_word(12'h004, rd); // ch 0 entry 1, low bits of 0x404
		read_word(12'h3FC, rd); // ch 3 entry 63, low bits of 0xFFC
		report_test("bad address");

		$display("tests: 6  checks: %0d  errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		#(TOTAL_CYC * 4 * CLK_PERIOD);
		$display("watchdog expired after %0d cycles with the run still going", TOTAL_CYC * 4);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+verification
common/fm_pkg.sv
spy_buffer/fm_passthrough_fifo.sv
spy_buffer/fm_spy_buffer.sv
rtl/fm_host_ctrl.sv
rtl/fm_top.sv
verification/fm_tb.sv
